// File: plic_pkg.sv
/* PLIC shared definitions */

package plic_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Sources are numbered 1..SRC_NUM, ID 0 means no interrupt
    localparam int unsigned SRC_NUM = 8;
    localparam int unsigned ID_W    = 4;
    localparam int unsigned PRIO_W  = 3;
    localparam int unsigned ADDR_W  = 8;
    localparam int unsigned DATA_W  = 32;

    // One bit per source, set means edge triggered (sources 5 to 8)
    localparam logic [SRC_NUM-1:0] LEVEL_EDGE_TRIGGER = 8'hF0;

    ////////////////////
    // Vector types
    ////////////////////

    typedef logic [SRC_NUM-1:0]        src_vec_t;
    typedef logic [ID_W-1:0]           irq_id_t;
    typedef logic [PRIO_W-1:0]         prio_t;
    // Source n sits at bits [(n-1)*PRIO_W +: PRIO_W]
    typedef logic [SRC_NUM*PRIO_W-1:0] prio_vec_t;
    typedef logic [ADDR_W-1:0]         reg_addr_t;
    typedef logic [DATA_W-1:0]         reg_data_t;

    ////////////////////
    // Register map
    ////////////////////

    // Priority of source n lives at PRIO_BASE + 4n
    localparam reg_addr_t PRIO_BASE    = 8'h00;
    localparam reg_addr_t PENDING_ADDR = 8'h40;
    localparam reg_addr_t ENABLE_ADDR  = 8'h44;
    localparam reg_addr_t THRESH_ADDR  = 8'h48;
    localparam reg_addr_t CLAIM_ADDR   = 8'h4C;
    localparam reg_addr_t MSIP_ADDR    = 8'h50;

endpackage : plic_pkg

// File: plic_gateway.sv
/* PLIC interrupt gateway */

`timescale 1ns/1ps

module plic_gateway (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Raw interrupt lines
    input  plic_pkg::src_vec_t intr_src_i,

    // Claim and complete strobes from the register file
    input  logic               claim_valid_i,
    input  plic_pkg::irq_id_t  claim_id_i,
    input  logic               complete_valid_i,
    input  plic_pkg::irq_id_t  complete_id_i,

    output plic_pkg::src_vec_t pending_o,
    output plic_pkg::src_vec_t eligible_o
);

    plic_pkg::src_vec_t src_q;
    plic_pkg::src_vec_t pending_q;
    plic_pkg::src_vec_t in_service_q;
    plic_pkg::src_vec_t rise;
    plic_pkg::src_vec_t claim_hit;
    plic_pkg::src_vec_t complete_hit;

    // Rising edges and ID decodes, bit i belongs to source i+1
    always_comb begin
        rise = intr_src_i & ~src_q;
        for (int i = 0; i < plic_pkg::SRC_NUM; i++) begin
            claim_hit[i]    = claim_valid_i && (claim_id_i == plic_pkg::irq_id_t'(i + 1));
            complete_hit[i] = complete_valid_i && (complete_id_i == plic_pkg::irq_id_t'(i + 1));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            src_q        <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            src_q <= intr_src_i;
            for (int i = 0; i < plic_pkg::SRC_NUM; i++) begin
                if (plic_pkg::LEVEL_EDGE_TRIGGER[i]) begin
                    // Edge source: a new edge wins over a claim in the same cycle
                    if (rise[i])
                        pending_q[i] <= 1'b1;
                    else if (claim_hit[i])
                        pending_q[i] <= 1'b0;
                end else begin
                    // Level source tracks the line only while not in service
                    if (claim_hit[i])
                        pending_q[i] <= 1'b0;
                    else if (!in_service_q[i])
                        pending_q[i] <= intr_src_i[i];
                end

                if (claim_hit[i])
                    in_service_q[i] <= 1'b1;
                else if (complete_hit[i])
                    in_service_q[i] <= 1'b0;
            end
        end
    end

    assign pending_o  = pending_q;
    // Sources in service stay hidden from the arbiter
    assign eligible_o = pending_q & ~in_service_q;

endmodule : plic_gateway

// File: plic_arbiter.sv
/* PLIC priority arbiter */

`timescale 1ns/1ps

module plic_arbiter (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  plic_pkg::src_vec_t  eligible_i,
    input  plic_pkg::src_vec_t  enable_i,
    input  plic_pkg::prio_vec_t prio_i,
    input  plic_pkg::prio_t     threshold_i,

    // Notification to the hart
    output logic                irq_o,
    output plic_pkg::irq_id_t   irq_id_o
);

    plic_pkg::src_vec_t candidate;
    plic_pkg::prio_t    best_prio;
    plic_pkg::irq_id_t  best_id;
    logic               irq_d;

    logic               irq_q;
    plic_pkg::irq_id_t  irq_id_q;

    ////////////////////
    // Selection
    ////////////////////

    assign candidate = eligible_i & enable_i;

    // Ascending scan with strict compare, so a tie keeps the lowest ID
    // and priority 0 can never be picked
    always_comb begin
        best_prio = '0;
        best_id   = '0;
        for (int i = 0; i < plic_pkg::SRC_NUM; i++) begin
            if (candidate[i] &&
                (prio_i[i*plic_pkg::PRIO_W +: plic_pkg::PRIO_W] > best_prio)) begin
                best_prio = prio_i[i*plic_pkg::PRIO_W +: plic_pkg::PRIO_W];
                best_id   = plic_pkg::irq_id_t'(i + 1);
            end
        end
    end

    // Must be strictly above the threshold
    assign irq_d = (best_prio > threshold_i);

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            irq_q    <= 1'b0;
            irq_id_q <= '0;
        end else begin
            irq_q    <= irq_d;
            irq_id_q <= irq_d ? best_id : '0;
        end
    end

    assign irq_o    = irq_q;
    assign irq_id_o = irq_id_q;

endmodule : plic_arbiter

// File: plic_regfile.sv
/* PLIC register file */

`timescale 1ns/1ps

module plic_regfile (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Register bus
    input  logic                reg_req_valid_i,
    input  logic                reg_req_write_i,
    input  plic_pkg::reg_addr_t reg_req_addr_i,
    input  plic_pkg::reg_data_t reg_req_wdata_i,
    output logic                reg_rsp_valid_o,
    output plic_pkg::reg_data_t reg_rsp_rdata_o,

    // Status from the gateway and arbiter
    input  plic_pkg::src_vec_t  pending_i,
    input  plic_pkg::irq_id_t   irq_id_i,

    // Configuration
    output plic_pkg::prio_vec_t prio_o,
    output plic_pkg::src_vec_t  enable_o,
    output plic_pkg::prio_t     threshold_o,

    // Strobes back to the gateway
    output logic                claim_valid_o,
    output plic_pkg::irq_id_t   claim_id_o,
    output logic                complete_valid_o,
    output plic_pkg::irq_id_t   complete_id_o,

    output logic                msip_o
);

    plic_pkg::prio_vec_t prio_q;
    plic_pkg::src_vec_t  enable_q;
    plic_pkg::prio_t     threshold_q;
    logic                msip_q;

    logic                wr_en;
    logic                rd_en;
    plic_pkg::reg_data_t rdata_d;

    logic                rsp_valid_q;
    plic_pkg::reg_data_t rsp_rdata_q;

    assign wr_en = reg_req_valid_i && reg_req_write_i;
    assign rd_en = reg_req_valid_i && !reg_req_write_i;

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prio_q      <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
            msip_q      <= 1'b0;
        end else if (wr_en) begin
            case (reg_req_addr_i)
                plic_pkg::ENABLE_ADDR: enable_q    <= reg_req_wdata_i[plic_pkg::SRC_NUM-1:0];
                plic_pkg::THRESH_ADDR: threshold_q <= reg_req_wdata_i[plic_pkg::PRIO_W-1:0];
                plic_pkg::MSIP_ADDR:   msip_q      <= reg_req_wdata_i[0];
                default: begin
                    for (int i = 0; i < plic_pkg::SRC_NUM; i++) begin
                        if (reg_req_addr_i ==
                            plic_pkg::reg_addr_t'(plic_pkg::PRIO_BASE + 4 * (i + 1)))
                            prio_q[i*plic_pkg::PRIO_W +: plic_pkg::PRIO_W] <=
                                reg_req_wdata_i[plic_pkg::PRIO_W-1:0];
                    end
                end
            endcase
        end
    end

    ////////////////////
    // Read side
    ////////////////////

    // Unmapped addresses fall through to zero
    always_comb begin
        rdata_d = '0;
        case (reg_req_addr_i)
            plic_pkg::PENDING_ADDR: rdata_d = plic_pkg::reg_data_t'(pending_i);
            plic_pkg::ENABLE_ADDR:  rdata_d = plic_pkg::reg_data_t'(enable_q);
            plic_pkg::THRESH_ADDR:  rdata_d = plic_pkg::reg_data_t'(threshold_q);
            plic_pkg::CLAIM_ADDR:   rdata_d = plic_pkg::reg_data_t'(irq_id_i);
            plic_pkg::MSIP_ADDR:    rdata_d = plic_pkg::reg_data_t'(msip_q);
            default: begin
                for (int i = 0; i < plic_pkg::SRC_NUM; i++) begin
                    if (reg_req_addr_i ==
                        plic_pkg::reg_addr_t'(plic_pkg::PRIO_BASE + 4 * (i + 1)))
                        rdata_d = plic_pkg::reg_data_t'(
                            prio_q[i*plic_pkg::PRIO_W +: plic_pkg::PRIO_W]);
                end
            end
        endcase
    end

    // Response one cycle after every request, writes return zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= reg_req_valid_i;
    end

    always_ff @(posedge clk_i) begin
        rsp_rdata_q <= rd_en ? rdata_d : '0;
    end

    // Claim takes the ID seen on the request cycle
    assign claim_valid_o    = rd_en && (reg_req_addr_i == plic_pkg::CLAIM_ADDR) &&
                              (irq_id_i != '0);
    assign claim_id_o       = irq_id_i;
    assign complete_valid_o = wr_en && (reg_req_addr_i == plic_pkg::CLAIM_ADDR);
    assign complete_id_o    = reg_req_wdata_i[plic_pkg::ID_W-1:0];

    assign reg_rsp_valid_o = rsp_valid_q;
    assign reg_rsp_rdata_o = rsp_rdata_q;
    assign prio_o          = prio_q;
    assign enable_o        = enable_q;
    assign threshold_o     = threshold_q;
    assign msip_o          = msip_q;

endmodule : plic_regfile

// File: plic_top.sv
/* PLIC top level */

`timescale 1ns/1ps

module plic_top (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  plic_pkg::src_vec_t  intr_src_i,

    input  logic                reg_req_valid_i,
    input  logic                reg_req_write_i,
    input  plic_pkg::reg_addr_t reg_req_addr_i,
    input  plic_pkg::reg_data_t reg_req_wdata_i,
    output logic                reg_rsp_valid_o,
    output plic_pkg::reg_data_t reg_rsp_rdata_o,

    output logic                irq_o,
    output plic_pkg::irq_id_t   irq_id_o,
    output logic                msip_o
);

    plic_pkg::src_vec_t  pending;
    plic_pkg::src_vec_t  eligible;
    plic_pkg::prio_vec_t prio;
    plic_pkg::src_vec_t  enable;
    plic_pkg::prio_t     threshold;
    logic                claim_valid;
    plic_pkg::irq_id_t   claim_id;
    logic                complete_valid;
    plic_pkg::irq_id_t   complete_id;

    plic_gateway gateway_u (
        .clk_i            ( clk_i          ),
        .rst_n_i          ( rst_n_i        ),
        .intr_src_i       ( intr_src_i     ),
        .claim_valid_i    ( claim_valid    ),
        .claim_id_i       ( claim_id       ),
        .complete_valid_i ( complete_valid ),
        .complete_id_i    ( complete_id    ),
        .pending_o        ( pending        ),
        .eligible_o       ( eligible       )
    );

    plic_arbiter arbiter_u (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .eligible_i  ( eligible  ),
        .enable_i    ( enable    ),
        .prio_i      ( prio      ),
        .threshold_i ( threshold ),
        .irq_o       ( irq_o     ),
        .irq_id_o    ( irq_id_o  )
    );

    // Claim reads see the registered arbiter ID
    plic_regfile regfile_u (
        .clk_i            ( clk_i           ),
        .rst_n_i          ( rst_n_i         ),
        .reg_req_valid_i  ( reg_req_valid_i ),
        .reg_req_write_i  ( reg_req_write_i ),
        .reg_req_addr_i   ( reg_req_addr_i  ),
        .reg_req_wdata_i  ( reg_req_wdata_i ),
        .reg_rsp_valid_o  ( reg_rsp_valid_o ),
        .reg_rsp_rdata_o  ( reg_rsp_rdata_o ),
        .pending_i        ( pending         ),
        .irq_id_i         ( irq_id_o        ),
        .prio_o           ( prio            ),
        .enable_o         ( enable          ),
        .threshold_o      ( threshold       ),
        .claim_valid_o    ( claim_valid     ),
        .claim_id_o       ( claim_id        ),
        .complete_valid_o ( complete_valid  ),
        .complete_id_o    ( complete_id     ),
        .msip_o           ( msip_o          )
    );

endmodule : plic_top

// File: tb_plic_top.sv
/* PLIC testbench */

`timescale 1ns/1ps

module tb_plic_top;

    localparam int RAND_ITERS      = 20;
    // 200 cycles for each directed test and each random round, plus margin
    localparam int WATCHDOG_CYCLES = (5 + RAND_ITERS) * 200 + 200;

    logic                clk;
    logic                rst_n;
    plic_pkg::src_vec_t  intr_src;
    logic                req_valid;
    logic                req_write;
    plic_pkg::reg_addr_t req_addr;
    plic_pkg::reg_data_t req_wdata;
    logic                rsp_valid;
    plic_pkg::reg_data_t rsp_rdata;
    logic                irq;
    plic_pkg::irq_id_t   irq_id;
    logic                msip;

    int                  checks    = 0;
    int                  errors    = 0;
    integer              seed      = 32'h285babd0;
    string               test_name = "init";
    plic_pkg::reg_data_t rnd;

    // Reference model copy of the configuration
    int                  m_prio [1:8];
    plic_pkg::src_vec_t  m_en;
    int                  m_thr;

    plic_top plic_top_i (
        .clk_i           ( clk       ),
        .rst_n_i         ( rst_n     ),
        .intr_src_i      ( intr_src  ),
        .reg_req_valid_i ( req_valid ),
        .reg_req_write_i ( req_write ),
        .reg_req_addr_i  ( req_addr  ),
        .reg_req_wdata_i ( req_wdata ),
        .reg_rsp_valid_o ( rsp_valid ),
        .reg_rsp_rdata_o ( rsp_rdata ),
        .irq_o           ( irq       ),
        .irq_id_o        ( irq_id    ),
        .msip_o          ( msip      )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Assertions
    ////////////////////

    // Response strobe exactly one cycle after each request
    assert property (@(posedge clk) disable iff (!rst_n) rsp_valid == $past(req_valid))
        else begin
            errors++;
            $display("** Error [%s] reg_rsp_valid_o: expected %b, actual %b",
                     test_name, !$sampled(rsp_valid), $sampled(rsp_valid));
        end

    assert property (@(posedge clk) disable iff (!rst_n) !irq |-> irq_id == '0)
        else begin
            errors++;
            $display("** Error [%s] irq_id_o with irq_o low: expected 0, actual %0d",
                     test_name, $sampled(irq_id));
        end

    task automatic expect_eq(input string what, input plic_pkg::reg_data_t exp,
                             input plic_pkg::reg_data_t act);
        checks++;
        assert (act == exp)
            else begin
                errors++;
                $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                         test_name, what, exp, act);
            end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n    = 1'b0;
        intr_src = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        m_en  = '0;
        m_thr = 0;
        for (int n = 1; n <= 8; n++)
            m_prio[n] = 0;
    endtask

    ////////////////////
    // Bus and line drivers
    ////////////////////

    task automatic bus_access(input logic write, input plic_pkg::reg_addr_t addr,
                              input plic_pkg::reg_data_t wdata,
                              output plic_pkg::reg_data_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp_valid) begin
            errors++;
            $display("[%s] bus response never arrived for address 0x%0h", test_name, addr);
        end
        data = rsp_rdata;
    endtask

    // Write responses carry zero data
    task automatic bus_write(input plic_pkg::reg_addr_t addr, input plic_pkg::reg_data_t wdata);
        plic_pkg::reg_data_t data;
        bus_access(1'b1, addr, wdata, data);
        expect_eq("write response data", '0, data);
    endtask

    task automatic read_expect(input string what, input plic_pkg::reg_addr_t addr,
                               input plic_pkg::reg_data_t exp);
        plic_pkg::reg_data_t data;
        bus_access(1'b0, addr, '0, data);
        expect_eq(what, exp, data);
    endtask

    function automatic plic_pkg::reg_addr_t prio_addr(input int n);
        return plic_pkg::reg_addr_t'(plic_pkg::PRIO_BASE + 4 * n);
    endfunction

    task automatic set_prio(input int n, input plic_pkg::reg_data_t val);
        bus_write(prio_addr(n), val);
        m_prio[n] = int'(val[2:0]);
    endtask

    task automatic set_enable(input plic_pkg::reg_data_t val);
        bus_write(plic_pkg::ENABLE_ADDR, val);
        m_en = val[7:0];
    endtask

    task automatic set_threshold(input plic_pkg::reg_data_t val);
        bus_write(plic_pkg::THRESH_ADDR, val);
        m_thr = int'(val[2:0]);
    endtask

    task automatic set_lines(input plic_pkg::src_vec_t v);
        @(negedge clk);
        intr_src = v;
    endtask

    task automatic pulse_source(input int n);
        @(negedge clk);
        intr_src[n-1] = 1'b1;
        @(negedge clk);
        intr_src[n-1] = 1'b0;
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Highest priority first, lowest ID first within it, only above threshold
    function automatic plic_pkg::irq_id_t model_id(input plic_pkg::src_vec_t pend);
        plic_pkg::irq_id_t id;
        id = '0;
        for (int p = 7; p > m_thr && id == '0; p--) begin
            for (int n = 1; n <= 8 && id == '0; n++) begin
                if (pend[n-1] && m_en[n-1] && m_prio[n] == p)
                    id = plic_pkg::irq_id_t'(n);
            end
        end
        return id;
    endfunction

    // pend holds the sources that the arbiter should see
    task automatic check_irq(input plic_pkg::src_vec_t pend);
        plic_pkg::irq_id_t id;
        id = model_id(pend);
        expect_eq("irq_o", plic_pkg::reg_data_t'(id != '0), plic_pkg::reg_data_t'(irq));
        expect_eq("irq_id_o", plic_pkg::reg_data_t'(id), plic_pkg::reg_data_t'(irq_id));
    endtask

    initial begin
        rst_n     = 1'b0;
        intr_src  = '0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;

        test_name = "reset";
        apply_reset();
        check_irq('0);
        expect_eq("msip_o", '0, plic_pkg::reg_data_t'(msip));
        for (int n = 1; n <= 8; n++)
            read_expect("priority", prio_addr(n), '0);
        read_expect("pending", plic_pkg::PENDING_ADDR, '0);
        read_expect("enable", plic_pkg::ENABLE_ADDR, '0);
        read_expect("threshold", plic_pkg::THRESH_ADDR, '0);
        read_expect("claim", plic_pkg::CLAIM_ADDR, '0);
        read_expect("msip", plic_pkg::MSIP_ADDR, '0);

        test_name = "readback";
        apply_reset();
        for (int n = 1; n <= 8; n++) begin
            rnd = $random(seed);
            set_prio(n, rnd);
            read_expect("priority", prio_addr(n), rnd & 32'h7);
        end
        rnd = $random(seed);
        set_enable(rnd);
        read_expect("enable", plic_pkg::ENABLE_ADDR, rnd & 32'hFF);
        rnd = $random(seed);
        set_threshold(rnd);
        read_expect("threshold", plic_pkg::THRESH_ADDR, rnd & 32'h7);
        bus_write(8'h00, 32'hFFFF_FFFF);
        read_expect("unmapped 0x00", 8'h00, '0);
        bus_write(8'h54, 32'hFFFF_FFFF);
        read_expect("unmapped 0x54", 8'h54, '0);
        bus_write(plic_pkg::MSIP_ADDR, 32'h3);
        read_expect("msip", plic_pkg::MSIP_ADDR, 32'h1);
        expect_eq("msip_o", 32'h1, plic_pkg::reg_data_t'(msip));
        bus_write(plic_pkg::MSIP_ADDR, 32'h0);
        expect_eq("msip_o", 32'h0, plic_pkg::reg_data_t'(msip));

        test_name = "level claim";
        apply_reset();
        set_prio(2, 32'd3);
        set_enable(32'h02);
        set_lines(8'h02);
        wait_cycles(3);
        check_irq(8'h02);
        read_expect("claim", plic_pkg::CLAIM_ADDR, 32'd2);
        wait_cycles(3);
        // Line still high, but the source is in service
        check_irq('0);
        bus_write(plic_pkg::CLAIM_ADDR, 32'd2);
        wait_cycles(3);
        check_irq(8'h02);
        set_lines('0);
        wait_cycles(3);
        check_irq('0);

        test_name = "edge capture";
        apply_reset();
        set_prio(6, 32'd5);
        set_enable(32'h20);
        pulse_source(6);
        wait_cycles(3);
        read_expect("pending", plic_pkg::PENDING_ADDR, 32'h20);
        wait_cycles(5);
        check_irq(8'h20);
        read_expect("claim", plic_pkg::CLAIM_ADDR, 32'd6);
        wait_cycles(3);
        check_irq('0);
        read_expect("pending", plic_pkg::PENDING_ADDR, '0);
        pulse_source(6);
        wait_cycles(3);
        check_irq('0);
        read_expect("pending", plic_pkg::PENDING_ADDR, 32'h20);
        bus_write(plic_pkg::CLAIM_ADDR, 32'd6);
        wait_cycles(3);
        check_irq(8'h20);

        test_name = "arbitration";
        apply_reset();
        set_prio(1, 32'd2);
        set_prio(2, 32'd5);
        set_prio(3, 32'd5);
        set_prio(4, 32'd7);
        set_enable(32'h07);
        set_lines(8'h0F);
        wait_cycles(3);
        check_irq(8'h0F);
        expect_eq("tie winner", 32'd2, plic_pkg::reg_data_t'(irq_id));
        set_prio(2, 32'd1);
        wait_cycles(3);
        check_irq(8'h0F);
        set_threshold(32'd5);
        wait_cycles(3);
        check_irq(8'h0F);
        set_enable(32'h0F);
        wait_cycles(3);
        check_irq(8'h0F);
        set_prio(4, 32'd0);
        set_threshold(32'd0);
        set_enable(32'h08);
        wait_cycles(3);
        check_irq(8'h0F);

        test_name = "random";
        apply_reset();
        for (int r = 0; r < RAND_ITERS; r++) begin
            for (int n = 1; n <= 8; n++) begin
                rnd = $random(seed);
                set_prio(n, rnd);
            end
            rnd = $random(seed);
            set_enable(rnd);
            rnd = $random(seed);
            set_threshold(rnd);
            rnd = $random(seed);
            // Level sources only, so nothing stays latched between rounds
            set_lines(plic_pkg::src_vec_t'(rnd[3:0]));
            wait_cycles(3);
            check_irq(plic_pkg::src_vec_t'(rnd[3:0]));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles during test %s", WATCHDOG_CYCLES, test_name);
        $display("TEST FAIL");
        $finish;
    end

endmodule : tb_plic_top

// File: vlog.f
plic_pkg.sv
plic_gateway.sv
plic_arbiter.sv
plic_regfile.sv
plic_top.sv
tb_plic_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PLIC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_plic_top -f vlog.f \
    -o tb_plic_top > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_plic_top > sim.log 2>&1 || { echo "Simulation error, see sim.log"; exit 1; }

grep -q "TEST FAIL" sim.log && { echo "Failures found, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No pass result in sim.log"; exit 1; }
echo "Simulation passed"
